// File: Bender.yml
package:
  name: image_uart_io

sources:
  - include_dirs:
      - include
    files:
      - design/link_pkg.sv
      - design/image_pkg.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/program_loader.sv
      - design/pixel_fetch.sv
      - design/channel_to_decimal.sv
      - design/ppm_serializer.sv
      - design/image_uart_io.sv
  - target: test
    files:
      - test/image_uart_io_assert.sv
      - test/tb_image_uart_io.sv

// File: build.f
+incdir+include
design/link_pkg.sv
design/image_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/program_loader.sv
design/pixel_fetch.sv
design/channel_to_decimal.sv
design/ppm_serializer.sv
design/image_uart_io.sv
test/image_uart_io_assert.sv
test/tb_image_uart_io.sv

// File: design/channel_to_decimal.sv
`timescale 1ns/1ps

module channel_to_decimal import image_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  channel_t value,
  input  logic     valid_in,
  output digit3_t  digits,
  output logic     valid_out
);

  digit_t     hund1;
  logic [6:0] rem1;  // below 100 after stage 1
  digit_t     hund2;
  digit_t     tens2;
  digit_t     ones2;
  digit_t     tens_c;
  logic       v1;
  logic       v2;

  // largest multiple of ten not above the remainder
  always_comb begin
    tens_c = '0;
    for (int i = 1; i < 10; i++) begin
      if (rem1 >= 7'(i * 10)) tens_c = digit_t'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (value >= 8'd200) begin
      hund1 <= 4'd2;
      rem1  <= 7'(value - 8'd200);
    end else if (value >= 8'd100) begin
      hund1 <= 4'd1;
      rem1  <= 7'(value - 8'd100);
    end else begin
      hund1 <= 4'd0;
      rem1  <= value[6:0];
    end
    hund2  <= hund1;
    tens2  <= tens_c;
    ones2  <= digit_t'(rem1 - 7'(tens_c * 10));
    digits <= {hund2, tens2, ones2};
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1        <= 1'b0;
      v2        <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      v1        <= valid_in;
      v2        <= v1;
      valid_out <= v2;  // three cycles, no stall
    end
  end

endmodule

// File: design/image_pkg.sv
package image_pkg;

  // one colour channel of a pixel
  typedef logic [7:0] channel_t;

  // one decimal digit
  typedef logic [3:0] digit_t;

  // [2] hundreds, [1] tens, [0] ones
  typedef digit_t [2:0] digit3_t;

endpackage

// File: design/image_uart_io.sv
`timescale 1ns/1ps
`include "ppm_consts.svh"

module image_uart_io #(
  parameter int img_width        = `PPM_DEF_WIDTH,
  parameter int img_height       = `PPM_DEF_HEIGHT,
  parameter int clk_per_half_bit = `PPM_CLK_PER_HALF_BIT
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        rxd,
  output logic        txd,
  output logic        wr_en_instr,
  output logic [31:0] addr_in_instr,
  output logic [31:0] data_in_instr,
  output logic        memread_io,
  output logic [31:0] addr_io,
  input  logic [31:0] data_from_memory_io,
  input  logic        data_ready_io,
  output logic        core_start,
  input  logic        core_end
);

  logic [7:0]        rx_data;
  logic              rx_valid;
  logic [7:0]        greet_byte;
  logic              greet_send;
  logic              greet_done;
  logic              load_done;
  logic              header_done;
  logic              credit_return;
  logic [2:0][7:0]   pix_ch;  // [2] red, [1] green, [0] blue
  logic              pix_valid;
  logic [2:0][11:0]  digits;
  logic [2:0]        digits_valid;

  uart_rx #(.clk_per_half_bit(clk_per_half_bit)) i_uart_rx (
    .clk   (clk),
    .rstn  (rstn),
    .rxd   (rxd),
    .data  (rx_data),
    .valid (rx_valid)
  );

  program_loader i_loader (
    .clk           (clk),
    .rstn          (rstn),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .greet_byte    (greet_byte),
    .greet_send    (greet_send),
    .greet_done    (greet_done),
    .wr_en_instr   (wr_en_instr),
    .addr_in_instr (addr_in_instr),
    .data_in_instr (data_in_instr),
    .core_start    (core_start),
    .load_done     (load_done)
  );

  pixel_fetch #(.num_pixels(img_width * img_height)) i_fetch (
    .clk                 (clk),
    .rstn                (rstn),
    .start               (header_done),
    .credit_return       (credit_return),
    .memread_io          (memread_io),
    .addr_io             (addr_io),
    .data_from_memory_io (data_from_memory_io),
    .data_ready_io       (data_ready_io),
    .pix_red             (pix_ch[2]),
    .pix_green           (pix_ch[1]),
    .pix_blue            (pix_ch[0]),
    .pix_valid           (pix_valid)
  );

  for (genvar c = 0; c < 3; c++) begin : g_conv
    channel_to_decimal i_conv (
      .clk       (clk),
      .rstn      (rstn),
      .value     (pix_ch[c]),
      .valid_in  (pix_valid),
      .digits    (digits[c]),
      .valid_out (digits_valid[c])
    );
  end

  ppm_serializer #(
    .img_width        (img_width),
    .img_height       (img_height),
    .clk_per_half_bit (clk_per_half_bit)
  ) i_serializer (
    .clk           (clk),
    .rstn          (rstn),
    .greet_byte    (greet_byte),
    .greet_send    (greet_send),
    .greet_done    (greet_done),
    .header_start  (load_done & core_end),
    .header_done   (header_done),
    .digits_red    (digits[2]),
    .digits_green  (digits[1]),
    .digits_blue   (digits[0]),
    .digits_valid  (&digits_valid),
    .credit_return (credit_return),
    .txd           (txd)
  );

endmodule

// File: design/link_pkg.sv
package link_pkg;

  // one byte on the uart line
  typedef logic [7:0] link_byte_t;

  // the receiver fills this one lane per byte, little endian,
  // and the loader reads it back as a single word
  typedef union packed {
    link_byte_t [3:0] lanes;
    logic [31:0]      word;
  } link_word_u;

  // program word count and instruction index
  typedef logic [29:0] prog_count_t;

endpackage

// File: design/pixel_fetch.sv
`timescale 1ns/1ps
`include "ppm_consts.svh"

module pixel_fetch import image_pkg::*; #(
  parameter int num_pixels = 16384
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        start,
  input  logic        credit_return,
  output logic        memread_io,
  output logic [31:0] addr_io,
  input  logic [31:0] data_from_memory_io,
  input  logic        data_ready_io,
  output channel_t    pix_red,
  output channel_t    pix_green,
  output channel_t    pix_blue,
  output logic        pix_valid
);

  localparam int credit_w = $clog2(`PPM_PIXEL_CREDITS + 1);
  localparam int idx_w    = $clog2(num_pixels + 1);

  logic                running;
  logic                pending;  // one read outstanding
  logic [credit_w-1:0] credits;
  logic [idx_w-1:0]    pix_idx;
  logic                issue;

  assign issue = running && !pending && credits != '0 && pix_idx != idx_w'(num_pixels);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      running     <= 1'b0;
      pending     <= 1'b0;
      credits     <= credit_w'(`PPM_PIXEL_CREDITS);
      pix_idx     <= '0;
      memread_io  <= 1'b0;
      pix_valid   <= 1'b0;
    end else begin
      if (start) running <= 1'b1;
      memread_io <= issue;
      pix_valid  <= pending && data_ready_io;
      if (issue) begin
        pending <= 1'b1;
        pix_idx <= pix_idx + 1'b1;
      end else if (data_ready_io) begin
        pending <= 1'b0;
      end
      credits <= credits + credit_w'(credit_return) - credit_w'(issue);
    end
  end

  always_ff @(posedge clk) begin
    if (issue) addr_io <= 32'(pix_idx) << 2;
    if (data_ready_io) begin
      pix_red   <= data_from_memory_io[7:0];
      pix_green <= data_from_memory_io[15:8];
      pix_blue  <= data_from_memory_io[23:16];
    end
  end

endmodule

// File: design/ppm_serializer.sv
`timescale 1ns/1ps
`include "ppm_consts.svh"

module ppm_serializer import link_pkg::*, image_pkg::*; #(
  parameter int img_width        = `PPM_DEF_WIDTH,
  parameter int img_height       = `PPM_DEF_HEIGHT,
  parameter int clk_per_half_bit = `PPM_CLK_PER_HALF_BIT
) (
  input  logic       clk,
  input  logic       rstn,
  input  link_byte_t greet_byte,
  input  logic       greet_send,
  output logic       greet_done,
  input  logic       header_start,
  output logic       header_done,
  input  digit3_t    digits_red,
  input  digit3_t    digits_green,
  input  digit3_t    digits_blue,
  input  logic       digits_valid,
  output logic       credit_return,
  output logic       txd
);

  function automatic link_byte_t dec_char(input int value);
    return `PPM_CHAR_ZERO + link_byte_t'(value % 10);
  endfunction

  // "P3\n" width " " height " 255\n", fixed at elaboration
  localparam logic [0:14][7:0] header = {
    `PPM_CHAR_P, dec_char(3), `PPM_CHAR_NEWLINE,
    dec_char(img_width / 100), dec_char(img_width / 10), dec_char(img_width),
    `PPM_CHAR_SPACE,
    dec_char(img_height / 100), dec_char(img_height / 10), dec_char(img_height),
    `PPM_CHAR_SPACE,
    dec_char(`PPM_MAX_COLOR / 100), dec_char(`PPM_MAX_COLOR / 10),
    dec_char(`PPM_MAX_COLOR), `PPM_CHAR_NEWLINE
  };

  localparam logic [2:0] M_IDLE    = 3'd0;  // greeting bytes accepted here
  localparam logic [2:0] M_GREET   = 3'd1;
  localparam logic [2:0] M_HEADER  = 3'd2;
  localparam logic [2:0] M_PIXWAIT = 3'd3;
  localparam logic [2:0] M_PIXEL   = 3'd4;

  logic [2:0]    mode;
  logic [3:0]    idx;  // byte within header or pixel line
  logic          wait_tx;
  logic          busy_q;
  logic          byte_done;
  logic          tx_start;
  logic          tx_busy;
  link_byte_t    tx_data;
  link_byte_t    next_byte;
  digit3_t [2:0] buf_mem [2];  // red in [2], blue in [0]
  digit3_t [2:0] cur_pix;
  digit3_t       sel;
  logic          wr_ptr;
  logic          rd_ptr;
  logic [1:0]    count;
  logic          push;
  logic          pop;

  assign byte_done = busy_q && !tx_busy;
  assign push      = digits_valid;
  assign pop       = mode == M_PIXWAIT && count != '0;

  // pixel line is "RRR GGG BBB\n", four bytes per channel
  always_comb begin
    sel = cur_pix[2'd2 - idx[3:2]];
    if (mode == M_HEADER) next_byte = header[idx];
    else if (idx[1:0] == 2'd3) next_byte = (idx[3:2] == 2'd2) ? `PPM_CHAR_NEWLINE : `PPM_CHAR_SPACE;
    else next_byte = `PPM_CHAR_ZERO + link_byte_t'(sel[2'd2 - idx[1:0]]);
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mode          <= M_IDLE;
      idx           <= '0;
      wait_tx       <= 1'b0;
      busy_q        <= 1'b0;
      tx_start      <= 1'b0;
      greet_done    <= 1'b0;
      header_done   <= 1'b0;
      credit_return <= 1'b0;
      wr_ptr        <= 1'b0;
      rd_ptr        <= 1'b0;
      count         <= '0;
    end else begin
      busy_q        <= tx_busy;
      tx_start      <= 1'b0;
      greet_done    <= 1'b0;
      header_done   <= 1'b0;
      credit_return <= 1'b0;
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      count <= count + 2'(push) - 2'(pop);
      if (byte_done) begin
        wait_tx <= 1'b0;
        case (mode)
          M_GREET: begin
            greet_done <= 1'b1;
            mode       <= M_IDLE;
          end
          M_HEADER: if (idx == 4'd14) begin
            header_done <= 1'b1;
            mode        <= M_PIXWAIT;
          end else begin
            idx <= idx + 1'b1;
          end
          M_PIXEL: if (idx == 4'd11) begin
            credit_return <= 1'b1;  // newline is out, fetcher may read again
            mode          <= M_PIXWAIT;
          end else begin
            idx <= idx + 1'b1;
          end
          default: ;
        endcase
      end else if (!wait_tx) begin
        case (mode)
          M_IDLE: if (greet_send) begin
            tx_start <= 1'b1;
            wait_tx  <= 1'b1;
            mode     <= M_GREET;
          end else if (header_start) begin
            idx  <= '0;
            mode <= M_HEADER;
          end
          M_HEADER, M_PIXEL: begin
            tx_start <= 1'b1;
            wait_tx  <= 1'b1;
          end
          M_PIXWAIT: if (pop) begin
            idx  <= '0;
            mode <= M_PIXEL;
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) buf_mem[wr_ptr] <= {digits_red, digits_green, digits_blue};
    if (pop) cur_pix <= buf_mem[rd_ptr];
    if (!wait_tx) tx_data <= (mode == M_IDLE) ? greet_byte : next_byte;
  end

  uart_tx #(
    .clk_per_half_bit(clk_per_half_bit)
  ) i_uart_tx (
    .clk   (clk),
    .rstn  (rstn),
    .data  (tx_data),
    .start (tx_start),
    .busy  (tx_busy),
    .txd   (txd)
  );

endmodule

// File: design/program_loader.sv
`timescale 1ns/1ps
`include "ppm_consts.svh"

module program_loader import link_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  link_byte_t  rx_data,
  input  logic        rx_valid,
  output link_byte_t  greet_byte,
  output logic        greet_send,
  input  logic        greet_done,
  output logic        wr_en_instr,
  output logic [31:0] addr_in_instr,
  output logic [31:0] data_in_instr,
  output logic        core_start,
  output logic        load_done
);

  localparam logic [2:0] S_GREET      = 3'd0;
  localparam logic [2:0] S_GREET_WAIT = 3'd1;
  localparam logic [2:0] S_COUNT      = 3'd2;  // byte count, 4 bytes
  localparam logic [2:0] S_SIZE       = 3'd3;
  localparam logic [2:0] S_WORD       = 3'd4;  // one program word, 4 bytes
  localparam logic [2:0] S_WRITE      = 3'd5;
  localparam logic [2:0] S_START_WAIT = 3'd6;
  localparam logic [2:0] S_DONE       = 3'd7;

  logic [2:0]  state;
  logic [1:0]  lane;
  link_word_u  rx_word;
  prog_count_t words;
  prog_count_t instr_idx;

  assign greet_byte    = core_start ? `PPM_STARTED : `PPM_GREETING;
  assign addr_in_instr = {instr_idx, 2'b00};
  assign data_in_instr = rx_word.word;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= S_GREET;
      lane        <= '0;
      instr_idx   <= '0;
      greet_send  <= 1'b0;
      wr_en_instr <= 1'b0;
      core_start  <= 1'b0;
      load_done   <= 1'b0;
    end else begin
      greet_send  <= 1'b0;
      wr_en_instr <= 1'b0;
      case (state)
        S_GREET: begin
          greet_send <= 1'b1;
          state      <= S_GREET_WAIT;
        end
        S_GREET_WAIT: if (greet_done) state <= S_COUNT;
        S_COUNT, S_WORD: if (rx_valid) begin
          lane <= lane + 1'b1;
          if (lane == 2'd3) begin
            wr_en_instr <= (state == S_WORD);  // word is complete next cycle
            state       <= (state == S_WORD) ? S_WRITE : S_SIZE;
          end
        end
        S_SIZE: begin
          if (rx_word.word[31:2] == '0) begin  // empty program
            core_start <= 1'b1;
            greet_send <= 1'b1;
            state      <= S_START_WAIT;
          end else begin
            state <= S_WORD;
          end
        end
        S_WRITE: begin
          instr_idx <= instr_idx + 1'b1;
          if (instr_idx == words - 1'b1) begin
            core_start <= 1'b1;  // stays up until reset
            greet_send <= 1'b1;  // announce the start with 0xaa
            state      <= S_START_WAIT;
          end else begin
            state <= S_WORD;
          end
        end
        S_START_WAIT: if (greet_done) begin
          load_done <= 1'b1;
          state     <= S_DONE;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && (state == S_COUNT || state == S_WORD)) rx_word.lanes[lane] <= rx_data;
    if (state == S_SIZE) words <= rx_word.word[31:2];  // bytes to words
  end

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps
`include "ppm_consts.svh"

module uart_rx import link_pkg::*; #(
  parameter int clk_per_half_bit = `PPM_CLK_PER_HALF_BIT
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rxd,
  output link_byte_t data,
  output logic       valid
);

  localparam int cnt_w = $clog2(2 * clk_per_half_bit);
  localparam logic [cnt_w-1:0] half_last = cnt_w'(clk_per_half_bit - 1);
  localparam logic [cnt_w-1:0] bit_last  = cnt_w'(2 * clk_per_half_bit - 1);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic [1:0]       state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  logic             rxd_meta;
  logic             rxd_s;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      valid    <= 1'b0;
    end else begin
      rxd_meta <= rxd;  // two-flop synchronizer
      rxd_s    <= rxd_meta;
      valid    <= 1'b0;
      cnt      <= cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!rxd_s) state <= RX_START;
        end
        RX_START: if (cnt == half_last) begin  // middle of the start bit
          cnt     <= '0;
          bit_idx <= '0;
          state   <= rxd_s ? RX_IDLE : RX_DATA;  // a glitch goes back to idle
        end
        RX_DATA: if (cnt == bit_last) begin
          cnt     <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= RX_STOP;
        end
        default: if (cnt == bit_last) begin
          valid <= rxd_s;  // no stop bit, no byte
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && cnt == bit_last) data <= {rxd_s, data[7:1]};
  end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps
`include "ppm_consts.svh"

module uart_tx import link_pkg::*; #(
  parameter int clk_per_half_bit = `PPM_CLK_PER_HALF_BIT
) (
  input  logic       clk,
  input  logic       rstn,
  input  link_byte_t data,
  input  logic       start,
  output logic       busy,
  output logic       txd
);

  localparam int cnt_w = $clog2(2 * clk_per_half_bit);
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(2 * clk_per_half_bit - 1);

  logic [cnt_w-1:0] cyc_cnt;
  logic [3:0]       bit_idx;  // 0 start, 1..8 data, 9 stop
  logic [8:0]       shreg;
  logic             load;
  logic             bit_end;

  assign load    = start && !busy;
  assign bit_end = busy && cyc_cnt == bit_last;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy    <= 1'b0;
      txd     <= 1'b1;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end else if (load) begin
      busy    <= 1'b1;
      txd     <= 1'b0;  // start bit
      cyc_cnt <= '0;
      bit_idx <= '0;
    end else if (bit_end) begin
      cyc_cnt <= '0;
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;  // stop bit done
      end else begin
        txd     <= shreg[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end else if (busy) begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  // stop bit sits above the data and shifts down behind it
  always_ff @(posedge clk) begin
    if (load) shreg <= {1'b1, data};
    else if (bit_end) shreg <= {1'b1, shreg[8:1]};
  end

endmodule

// File: include/ppm_consts.svh
`ifndef PPM_CONSTS_SVH
`define PPM_CONSTS_SVH

// ascii codes used in the image text
`define PPM_CHAR_P       8'h50
`define PPM_CHAR_ZERO    8'h30
`define PPM_CHAR_SPACE   8'h20
`define PPM_CHAR_NEWLINE 8'h0a

// handshake bytes sent to the host
`define PPM_GREETING 8'h99  // ready for a program
`define PPM_STARTED  8'haa  // core has been started

`define PPM_DEF_WIDTH  32'd128
`define PPM_DEF_HEIGHT 32'd128

`define PPM_CLK_PER_HALF_BIT 100  // clock cycles per half uart bit
`define PPM_PIXEL_CREDITS    2    // pixels allowed ahead of the serializer
`define PPM_MAX_COLOR        255

`endif

// File: test/image_uart_io_assert.sv
`timescale 1ns/1ps

module image_uart_io_assert (
  input logic clk,
  input logic rstn,
  input logic memread_io,
  input logic core_start,
  input logic txd
);

  // one read outstanding, so each request is a single pulse
  a_memread_pulse: assert property (
    @(posedge clk) disable iff (!rstn) memread_io |=> !memread_io
  ) else $error("memread_io high on two consecutive cycles");

  a_core_start_held: assert property (
    @(posedge clk) disable iff (!rstn) core_start |=> core_start
  ) else $error("core_start fell without a reset");

  // line idles high while in reset
  a_txd_idle_in_reset: assert property (
    @(posedge clk) !rstn |=> txd
  ) else $error("txd low during reset");

endmodule

// File: test/tb_image_uart_io.sv
`timescale 1ns/1ps

module tb_image_uart_io;

  localparam int width        = 4;
  localparam int height       = 3;
  localparam int half_bit     = 4;
  localparam int num_pix      = width * height;
  localparam int bit_cycles   = 2 * half_bit;
  localparam int byte_timeout = 4000;   // cycles per received byte
  localparam int start_limit  = 20000;  // cycles until core_start
  localparam logic [7:0] greeting = 8'h99;
  localparam logic [7:0] started  = 8'haa;

  logic        clk = 1'b0;  // starts low so time zero has no edge
  logic        rstn;
  logic        rxd;
  logic        txd;
  logic        wr_en_instr;
  logic [31:0] addr_in_instr;
  logic [31:0] data_in_instr;
  logic        memread_io;
  logic [31:0] addr_io;
  logic [31:0] data_from_memory_io;
  logic        data_ready_io;
  logic        core_start;
  logic        core_end;

  logic [31:0] lcg_state;
  int          value_errs = 0;
  int          proto_errs = 0;
  int          timeouts = 0;
  int          num_words = 0;
  int          run_cycles = 0;
  int          reads = 0;
  int          total_writes = 0;
  int          writes_at_start = 0;
  bit          start_seen = 1'b0;
  bit          memread_q = 1'b0;
  logic [31:0] prog [16];
  logic [31:0] instr_mem [16];
  int          write_cnt [16] = '{default: 0};
  logic [31:0] pix_mem [num_pix];
  int          lat [num_pix];
  logic [7:0]  rx_q [$];  // bytes seen on txd

  image_uart_io #(
    .img_width        (width),
    .img_height       (height),
    .clk_per_half_bit (half_bit)
  ) i_image_uart_io (
    .clk                 (clk),
    .rstn                (rstn),
    .rxd                 (rxd),
    .txd                 (txd),
    .wr_en_instr         (wr_en_instr),
    .addr_in_instr       (addr_in_instr),
    .data_in_instr       (data_in_instr),
    .memread_io          (memread_io),
    .addr_io             (addr_io),
    .data_from_memory_io (data_from_memory_io),
    .data_ready_io       (data_ready_io),
    .core_start          (core_start),
    .core_end            (core_end)
  );

  bind image_uart_io image_uart_io_assert i_assert (
    .clk        (clk),
    .rstn       (rstn),
    .memread_io (memread_io),
    .core_start (core_start),
    .txd        (txd)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int random_below(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r[31:16]) % n;  // upper bits are the better ones
  endfunction

  // expected text line of one pixel
  function automatic string pixel_text(input logic [31:0] word);
    return $sformatf("%03d %03d %03d\n", word[7:0], word[15:8], word[23:16]);
  endfunction

  task automatic finish_run();
    $display("error counts: %0d value, %0d protocol, %0d timeout",
             value_errs, proto_errs, timeouts);
    if (value_errs + proto_errs + timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // host side of the uart, 8N1, lsb first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd = frame[i];
      repeat (bit_cycles) @(negedge clk);
    end
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      send_byte(w[8*i +: 8]);  // little endian
    end
  endtask

  task automatic get_byte(output logic [7:0] b, input string what);
    int waited;
    waited = 0;
    while (rx_q.size() == 0 && waited < byte_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (rx_q.size() == 0) begin
      $display("timeout: no byte arrived on txd while waiting for the %s", what);
      timeouts++;
      finish_run();
    end else begin
      b = rx_q.pop_front();
    end
  endtask

  task automatic expect_text(input string exp, input string what);
    logic [7:0] b;
    for (int i = 0; i < exp.len(); i++) begin
      get_byte(b, what);
      if (b !== exp[i]) begin
        $display("FAIL t=%0t: %s byte %0d is 0x%02h, expected 0x%02h",
                 $time, what, i, b, exp[i]);
        value_errs++;
      end
    end
  endtask

  // host receiver, samples each bit near its middle
  initial begin : host_receiver
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (rstn === 1'b1 && txd === 1'b0) begin
        repeat (half_bit - 1) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (bit_cycles) @(negedge clk);
          b[i] = txd;
        end
        repeat (bit_cycles) @(negedge clk);
        if (txd !== 1'b1) begin
          $display("protocol error at %0t: stop bit missing on txd", $time);
          proto_errs++;
        end
        rx_q.push_back(b);
      end
    end
  end

  // instruction memory and handshake rules
  always @(negedge clk) begin
    int idx;
    if (rstn === 1'b1) begin
      if (memread_io === 1'b1 && memread_q) begin
        $display("protocol error at %0t: memread_io high for two cycles", $time);
        proto_errs++;
      end
      memread_q = (memread_io === 1'b1);
      if (start_seen && core_start !== 1'b1) begin
        $display("protocol error at %0t: core_start fell after rising", $time);
        proto_errs++;
      end
      if (wr_en_instr === 1'b1) begin
        idx = int'(addr_in_instr >> 2);
        if (core_start === 1'b1) begin
          $display("protocol error at %0t: instruction write after core_start", $time);
          proto_errs++;
        end
        if (addr_in_instr[1:0] != 2'b00 || addr_in_instr >= 32'(4 * num_words)) begin
          $display("protocol error at %0t: instruction write to address 0x%08h",
                   $time, addr_in_instr);
          proto_errs++;
        end else begin
          write_cnt[idx]++;
          instr_mem[idx] = data_in_instr;
          total_writes++;
        end
      end
      if (core_start === 1'b1 && !start_seen) begin
        start_seen      = 1'b1;
        writes_at_start = total_writes;
      end
    end
  end

  // data memory with a random answer delay per read
  initial begin : data_memory
    data_ready_io       = 1'b0;
    data_from_memory_io = '0;
    forever begin
      @(negedge clk);
      if (rstn === 1'b1 && memread_io === 1'b1) begin
        if (reads >= num_pix) begin
          $display("protocol error at %0t: read beyond the last pixel", $time);
          proto_errs++;
          data_ready_io = 1'b1;
        end else begin
          if (addr_io !== 32'(4 * reads)) begin
            $display("FAIL t=%0t: read address 0x%08h, expected 0x%08h",
                     $time, addr_io, 32'(4 * reads));
            value_errs++;
          end
          repeat (lat[reads]) @(negedge clk);
          data_ready_io       = 1'b1;
          data_from_memory_io = pix_mem[reads];
        end
        @(negedge clk);
        data_ready_io       = 1'b0;
        data_from_memory_io = '0;
        reads++;
      end
    end
  end

  // core runs for a while once started
  initial begin : core_model
    int waited;
    core_end = 1'b0;
    waited   = 0;
    while (core_start !== 1'b1 && waited < start_limit) begin
      @(negedge clk);
      waited++;
    end
    if (core_start !== 1'b1) begin
      $display("timeout: core_start never rose");
      timeouts++;
      finish_run();
    end else begin
      repeat (run_cycles) @(negedge clk);
      core_end = 1'b1;
    end
  end

  initial begin : main_flow
    logic [7:0] b;
    string      header;
    lcg_state = 32'd50;
    rstn      = 1'b0;
    rxd       = 1'b1;
    num_words = 1 + random_below(12);
    for (int k = 0; k < num_words; k++) begin
      prog[k] = next_random();
    end
    for (int i = 0; i < num_pix; i++) begin
      pix_mem[i] = next_random();
      lat[i]     = random_below(4);
    end
    run_cycles = 10 + random_below(50);
    header     = $sformatf("P3\n%03d %03d %0d\n", width, height, 255);

    repeat (4) @(negedge clk);
    if (txd !== 1'b1 || wr_en_instr !== 1'b0 || memread_io !== 1'b0 ||
        core_start !== 1'b0) begin
      $display("FAIL t=%0t: outputs not idle in reset (txd %b wr %b rd %b start %b)",
               $time, txd, wr_en_instr, memread_io, core_start);
      value_errs++;
    end
    rstn = 1'b1;

    get_byte(b, "greeting");
    if (b !== greeting) begin
      $display("FAIL t=%0t: first byte 0x%02h, expected 0x%02h", $time, b, greeting);
      value_errs++;
    end

    send_word(32'(4 * num_words));  // byte count
    for (int k = 0; k < num_words; k++) begin
      send_word(prog[k]);
    end

    get_byte(b, "start byte");
    if (b !== started) begin
      $display("FAIL t=%0t: start byte 0x%02h, expected 0x%02h", $time, b, started);
      value_errs++;
    end
    if (core_start !== 1'b1) begin
      $display("FAIL t=%0t: core_start low after the start byte", $time);
      value_errs++;
    end
    if (writes_at_start != num_words) begin
      $display("FAIL t=%0t: core_start rose after %0d of %0d writes",
               $time, writes_at_start, num_words);
      value_errs++;
    end
    for (int k = 0; k < num_words; k++) begin
      if (write_cnt[k] != 1) begin
        $display("FAIL t=%0t: word %0d written %0d times", $time, k, write_cnt[k]);
        value_errs++;
      end else if (instr_mem[k] !== prog[k]) begin
        $display("FAIL t=%0t: word %0d is 0x%08h, expected 0x%08h",
                 $time, k, instr_mem[k], prog[k]);
        value_errs++;
      end
    end

    expect_text(header, "image header");
    for (int i = 0; i < num_pix; i++) begin
      expect_text(pixel_text(pix_mem[i]), $sformatf("pixel %0d", i));
    end

    repeat (20 * bit_cycles) @(negedge clk);  // line must stay quiet now
    if (rx_q.size() != 0) begin
      $display("protocol error: %0d extra bytes after the last pixel", rx_q.size());
      proto_errs++;
    end
    if (reads != num_pix) begin
      $display("FAIL t=%0t: %0d memory reads, expected %0d", $time, reads, num_pix);
      value_errs++;
    end
    finish_run();
  end

endmodule
